// File: common/core_pkg.sv
package core_pkg;

	// ------------------------------
	// Widths
	// ------------------------------
	localparam int DATA_W  = 8;
	localparam int PC_W    = 10;
	localparam int REG_W   = 3;
	localparam int DADDR_W = 8;
	localparam int OPC_W   = 5;

	// ------------------------------
	// Opcodes
	// ------------------------------
	// 0x03 to 0x05 fall through to NOP
	localparam logic [OPC_W-1:0] OPC_NOP   = 5'h00;
	localparam logic [OPC_W-1:0] OPC_ADD   = 5'h01;
	localparam logic [OPC_W-1:0] OPC_SUB   = 5'h02;
	localparam logic [OPC_W-1:0] OPC_SHL   = 5'h06;
	localparam logic [OPC_W-1:0] OPC_JMP   = 5'h07;
	localparam logic [OPC_W-1:0] OPC_LOAD  = 5'h08;
	localparam logic [OPC_W-1:0] OPC_STORE = 5'h09;
	localparam logic [OPC_W-1:0] OPC_AND   = 5'h0a;
	localparam logic [OPC_W-1:0] OPC_OR    = 5'h0b;
	localparam logic [OPC_W-1:0] OPC_NOT   = 5'h0c;
	localparam logic [OPC_W-1:0] OPC_CMP   = 5'h0d;
	localparam logic [OPC_W-1:0] OPC_JMPGT = 5'h0e;
	localparam logic [OPC_W-1:0] OPC_JMPLT = 5'h0f;
	localparam logic [OPC_W-1:0] OPC_JMPEQ = 5'h10;
	localparam logic [OPC_W-1:0] OPC_JMPC  = 5'h11;

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [PC_W-1:0]    pc_t;
	typedef logic [REG_W-1:0]   reg_addr_t;
	typedef logic [DADDR_W-1:0] dmem_addr_t;

	// ------------------------------
	// Instruction word views
	// ------------------------------
	// ALU and compare, bits 7 and 3 unused
	typedef struct packed {
		logic [OPC_W-1:0] opcode;
		reg_addr_t        dest;
		logic             rsvd_hi;
		reg_addr_t        op2;
		logic             rsvd_lo;
		reg_addr_t        op1;
	} alu_fmt_t;

	typedef struct packed {
		logic [OPC_W-1:0] opcode;
		reg_addr_t        dest;
		dmem_addr_t       addr;
	} load_fmt_t;

	// Address sits in [10:3], source register in [2:0]
	typedef struct packed {
		logic [OPC_W-1:0] opcode;
		dmem_addr_t       addr;
		reg_addr_t        op1;
	} store_fmt_t;

	typedef struct packed {
		logic [OPC_W-1:0] opcode;
		logic             rsvd;
		pc_t              target;
	} branch_fmt_t;

	// Same 16 bits, four decodings
	typedef union packed {
		alu_fmt_t    alu;
		load_fmt_t   load;
		store_fmt_t  store;
		branch_fmt_t branch;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SHL,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_PASS
	} alu_op_t;

	typedef enum logic [2:0] {
		JC_NONE,
		JC_ALWAYS,
		JC_GT,
		JC_LT,
		JC_EQ,
		JC_CARRY
	} jump_cond_t;

	// Decode to execute register contents
	typedef struct packed {
		logic       valid;
		alu_op_t    alu_op;
		logic       load;
		logic       store;
		logic       reg_write;
		logic       compare;
		logic       set_carry;
		jump_cond_t jump_cond;
		pc_t        branch_target;
		reg_addr_t  op1_addr;
		reg_addr_t  op2_addr;
		data_t      op1_data;
		data_t      op2_data;
		reg_addr_t  dest;
		dmem_addr_t mem_addr;
	} ex_bundle_t;

endpackage

// File: rtl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
	input  logic             clk,
	input  logic             reset,
	input  logic             branch_taken,
	input  core_pkg::pc_t    branch_target,
	input  core_pkg::instr_t instr_mem_data,
	output core_pkg::pc_t    prog_ctr,
	output core_pkg::instr_t dec_instr,
	output logic             dec_valid
);

	// ------------------------------
	// Program counter
	// ------------------------------
	// Branch from execute redirects at the same edge
	always_ff @(posedge clk)
	begin
		if (reset)
			prog_ctr <= '0;
		else if (branch_taken)
			prog_ctr <= branch_target;
		else
			prog_ctr <= prog_ctr + 1'b1;
	end

	// ------------------------------
	// Decode-stage instruction register
	// ------------------------------
	always_ff @(posedge clk)
	begin
		dec_instr <= instr_mem_data;
	end

	// Word fetched at a taken-branch edge is the wrong path
	always_ff @(posedge clk)
	begin
		if (reset)
			dec_valid <= 1'b0;
		else
			dec_valid <= !branch_taken;
	end

	// Sequential fetch unless redirected
	a_pc_step: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) && !$past(branch_taken)
		|-> prog_ctr == core_pkg::pc_t'($past(prog_ctr) + 1'b1));

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  core_pkg::instr_t      dec_instr,
	input  logic                  dec_valid,
	input  logic                  branch_taken,
	input  core_pkg::data_t       op1_rd_data,
	input  core_pkg::data_t       op2_rd_data,
	input  logic                  wb_valid,
	input  core_pkg::reg_addr_t   dest_reg_addr,
	input  core_pkg::data_t       wb_data,
	output core_pkg::reg_addr_t   op1_addr,
	output core_pkg::reg_addr_t   op2_addr,
	output core_pkg::ex_bundle_t  ex_bundle
);

	core_pkg::ex_bundle_t ex_dec;
	core_pkg::ex_bundle_t ex_next;
	core_pkg::data_t      op1_fwd;
	core_pkg::data_t      op2_fwd;

	// ------------------------------
	// Opcode decoder
	// ------------------------------
	always_comb
	begin
		// NOP unless the opcode says otherwise
		ex_dec           = '0;
		ex_dec.alu_op    = core_pkg::ALU_PASS;
		ex_dec.jump_cond = core_pkg::JC_NONE;
		// Register fields sit at the same bits in every view
		op1_addr         = dec_instr.alu.op1;
		op2_addr         = dec_instr.alu.op2;
		ex_dec.dest      = dec_instr.alu.dest;
		case (dec_instr.alu.opcode)
			core_pkg::OPC_ADD:
			begin
				ex_dec.alu_op    = core_pkg::ALU_ADD;
				ex_dec.reg_write = 1'b1;
				ex_dec.set_carry = 1'b1;
			end
			core_pkg::OPC_SUB:
			begin
				ex_dec.alu_op    = core_pkg::ALU_SUB;
				ex_dec.reg_write = 1'b1;
				ex_dec.set_carry = 1'b1;
			end
			core_pkg::OPC_SHL:
			begin
				ex_dec.alu_op    = core_pkg::ALU_SHL;
				ex_dec.reg_write = 1'b1;
				ex_dec.set_carry = 1'b1;
			end
			core_pkg::OPC_AND:
			begin
				ex_dec.alu_op    = core_pkg::ALU_AND;
				ex_dec.reg_write = 1'b1;
			end
			core_pkg::OPC_OR:
			begin
				ex_dec.alu_op    = core_pkg::ALU_OR;
				ex_dec.reg_write = 1'b1;
			end
			core_pkg::OPC_NOT:
			begin
				ex_dec.alu_op    = core_pkg::ALU_NOT;
				ex_dec.reg_write = 1'b1;
			end
			// Subtract for flags only
			core_pkg::OPC_CMP:
			begin
				ex_dec.alu_op  = core_pkg::ALU_SUB;
				ex_dec.compare = 1'b1;
			end
			core_pkg::OPC_LOAD:
			begin
				ex_dec.load      = 1'b1;
				ex_dec.reg_write = 1'b1;
				ex_dec.mem_addr  = dec_instr.load.addr;
			end
			// Store data goes through the ALU as a pass of op1
			core_pkg::OPC_STORE:
			begin
				ex_dec.store    = 1'b1;
				ex_dec.mem_addr = dec_instr.store.addr;
			end
			core_pkg::OPC_JMP:
				ex_dec.jump_cond = core_pkg::JC_ALWAYS;
			core_pkg::OPC_JMPGT:
				ex_dec.jump_cond = core_pkg::JC_GT;
			core_pkg::OPC_JMPLT:
				ex_dec.jump_cond = core_pkg::JC_LT;
			core_pkg::OPC_JMPEQ:
				ex_dec.jump_cond = core_pkg::JC_EQ;
			core_pkg::OPC_JMPC:
				ex_dec.jump_cond = core_pkg::JC_CARRY;
			default:
			begin
				// Unknown and dropped logical opcodes stay NOP
			end
		endcase
		ex_dec.branch_target = dec_instr.branch.target;
		ex_dec.op1_addr      = op1_addr;
		ex_dec.op2_addr      = op2_addr;
		ex_dec.valid         = dec_valid && !branch_taken;
	end

	// ------------------------------
	// Forwarding from writeback
	// ------------------------------
	// Producer two ahead has not reached the register file yet
	assign op1_fwd = (wb_valid && dest_reg_addr == op1_addr) ? wb_data : op1_rd_data;
	assign op2_fwd = (wb_valid && dest_reg_addr == op2_addr) ? wb_data : op2_rd_data;

	always_comb
	begin
		ex_next          = ex_dec;
		ex_next.op1_data = op1_fwd;
		ex_next.op2_data = op2_fwd;
	end

	// Decode to execute register
	always_ff @(posedge clk)
	begin
		ex_bundle <= ex_next;
		if (reset)
			ex_bundle.valid <= 1'b0;
	end

	// Store never writes a register and is never a load
	a_enables_exclusive: assert property (@(posedge clk) disable iff (reset)
		ex_bundle.valid && ex_bundle.store |-> !(ex_bundle.load || ex_bundle.reg_write));

endmodule

// File: execute/alu.sv
`timescale 1ns/1ns

module alu (
	input  core_pkg::alu_op_t alu_op,
	input  core_pkg::data_t   op_a,
	input  core_pkg::data_t   op_b,
	output core_pkg::data_t   result,
	output logic              carry_out,
	output logic              gt,
	output logic              lt,
	output logic              eq
);

	// ------------------------------
	// Datapath
	// ------------------------------
	always_comb
	begin
		result    = op_a;
		carry_out = 1'b0;
		case (alu_op)
			core_pkg::ALU_ADD:
				{carry_out, result} = {1'b0, op_a} + {1'b0, op_b};
			// Two's complement, carry set means no borrow
			core_pkg::ALU_SUB:
				{carry_out, result} = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;
			core_pkg::ALU_SHL:
			begin
				carry_out = op_a[core_pkg::DATA_W-1];
				result    = {op_a[core_pkg::DATA_W-2:0], 1'b0};
			end
			core_pkg::ALU_AND:
				result = op_a & op_b;
			core_pkg::ALU_OR:
				result = op_a | op_b;
			core_pkg::ALU_NOT:
				result = ~op_a;
			default:
				result = op_a;
		endcase
	end

	// ------------------------------
	// Compare flags
	// ------------------------------
	// Meaningful only after a subtract
	assign eq = (result == '0);
	assign gt = carry_out && !eq;
	assign lt = !carry_out && !eq;

endmodule

// File: execute/execute_writeback.sv
`timescale 1ns/1ns

module execute_writeback (
	input  logic                  clk,
	input  logic                  reset,
	input  core_pkg::ex_bundle_t  ex_bundle,
	input  core_pkg::data_t       datamem_rd_data,
	output logic                  branch_taken,
	output core_pkg::pc_t         branch_target,
	output logic                  wb_valid,
	output core_pkg::reg_addr_t   dest_reg_addr,
	output core_pkg::data_t       wb_data,
	output logic                  reg_wr_en,
	output logic                  store_to_mem,
	output core_pkg::dmem_addr_t  data_rd_addr,
	output core_pkg::dmem_addr_t  data_wr_addr
);

	// Writeback register contents
	typedef struct packed {
		logic                 reg_write;
		logic                 store;
		logic                 load;
		core_pkg::data_t      result;
		core_pkg::dmem_addr_t mem_addr;
		core_pkg::reg_addr_t  dest;
	} wb_reg_t;

	wb_reg_t         wb_q;
	core_pkg::data_t op_a;
	core_pkg::data_t op_b;
	core_pkg::data_t alu_result;
	logic            alu_carry;
	logic            alu_gt;
	logic            alu_lt;
	logic            alu_eq;
	logic            gt_q;
	logic            lt_q;
	logic            eq_q;
	logic            carry_q;
	logic            cond_met;

	// ------------------------------
	// Execute forwarding
	// ------------------------------
	// Producer directly ahead is now in writeback
	assign op_a = (wb_valid && dest_reg_addr == ex_bundle.op1_addr) ? wb_data
		: ex_bundle.op1_data;
	assign op_b = (wb_valid && dest_reg_addr == ex_bundle.op2_addr) ? wb_data
		: ex_bundle.op2_data;

	alu u_alu (
		.alu_op    (ex_bundle.alu_op),
		.op_a      (op_a),
		.op_b      (op_b),
		.result    (alu_result),
		.carry_out (alu_carry),
		.gt        (alu_gt),
		.lt        (alu_lt),
		.eq        (alu_eq)
	);

	// ------------------------------
	// Branch decision
	// ------------------------------
	always_comb
	begin
		case (ex_bundle.jump_cond)
			core_pkg::JC_ALWAYS: cond_met = 1'b1;
			core_pkg::JC_GT:     cond_met = gt_q;
			core_pkg::JC_LT:     cond_met = lt_q;
			core_pkg::JC_EQ:     cond_met = eq_q;
			core_pkg::JC_CARRY:  cond_met = carry_q;
			default:             cond_met = 1'b0;
		endcase
	end

	assign branch_taken  = ex_bundle.valid && cond_met;
	assign branch_target = ex_bundle.branch_target;

	// Flags commit as the setter leaves execute
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			gt_q    <= 1'b0;
			lt_q    <= 1'b0;
			eq_q    <= 1'b0;
			carry_q <= 1'b0;
		end
		else
		begin
			if (ex_bundle.valid && ex_bundle.compare)
			begin
				gt_q <= alu_gt;
				lt_q <= alu_lt;
				eq_q <= alu_eq;
			end
			if (ex_bundle.valid && ex_bundle.set_carry)
				carry_q <= alu_carry;
		end
	end

	// ------------------------------
	// Writeback register
	// ------------------------------
	always_ff @(posedge clk)
	begin
		wb_q.load     <= ex_bundle.load;
		wb_q.result   <= alu_result;
		wb_q.mem_addr <= ex_bundle.mem_addr;
		wb_q.dest     <= ex_bundle.dest;
		// Squashed slots carry no enables
		if (reset)
		begin
			wb_q.reg_write <= 1'b0;
			wb_q.store     <= 1'b0;
		end
		else
		begin
			wb_q.reg_write <= ex_bundle.valid && ex_bundle.reg_write;
			wb_q.store     <= ex_bundle.valid && ex_bundle.store;
		end
	end

	// Async data memory read lands in the same cycle
	assign wb_data       = wb_q.load ? datamem_rd_data : wb_q.result;
	assign wb_valid      = wb_q.reg_write;
	assign reg_wr_en     = wb_q.reg_write;
	assign store_to_mem  = wb_q.store;
	assign dest_reg_addr = wb_q.dest;
	assign data_rd_addr  = wb_q.mem_addr;
	assign data_wr_addr  = wb_q.mem_addr;

	a_single_commit: assert property (@(posedge clk) disable iff (reset)
		!(reg_wr_en && store_to_mem));

endmodule

// File: rtl/processor_core.sv
`timescale 1ns/1ns

module processor_core (
	input  logic                  clk,
	input  logic                  reset,
	input  core_pkg::instr_t      instr_mem_data,
	output core_pkg::pc_t         prog_ctr,
	output core_pkg::reg_addr_t   op1_addr,
	output core_pkg::reg_addr_t   op2_addr,
	input  core_pkg::data_t       op1_rd_data,
	input  core_pkg::data_t       op2_rd_data,
	output logic                  reg_wr_en,
	output core_pkg::reg_addr_t   dest_reg_addr,
	output core_pkg::data_t       wb_data,
	output logic                  store_to_mem,
	output core_pkg::dmem_addr_t  data_rd_addr,
	output core_pkg::dmem_addr_t  data_wr_addr,
	input  core_pkg::data_t       datamem_rd_data
);

	core_pkg::instr_t     dec_instr;
	core_pkg::ex_bundle_t ex_bundle;
	core_pkg::pc_t        branch_target;
	logic                 dec_valid;
	logic                 branch_taken;
	logic                 wb_valid;

	// Fetch and decode register
	fetch_unit u_fetch (
		.clk            (clk),
		.reset          (reset),
		.branch_taken   (branch_taken),
		.branch_target  (branch_target),
		.instr_mem_data (instr_mem_data),
		.prog_ctr       (prog_ctr),
		.dec_instr      (dec_instr),
		.dec_valid      (dec_valid)
	);

	decode_stage u_decode (
		.clk           (clk),
		.reset         (reset),
		.dec_instr     (dec_instr),
		.dec_valid     (dec_valid),
		.branch_taken  (branch_taken),
		.op1_rd_data   (op1_rd_data),
		.op2_rd_data   (op2_rd_data),
		.wb_valid      (wb_valid),
		.dest_reg_addr (dest_reg_addr),
		.wb_data       (wb_data),
		.op1_addr      (op1_addr),
		.op2_addr      (op2_addr),
		.ex_bundle     (ex_bundle)
	);

	// Execute plus writeback, owns the flags
	execute_writeback u_exwb (
		.clk             (clk),
		.reset           (reset),
		.ex_bundle       (ex_bundle),
		.datamem_rd_data (datamem_rd_data),
		.branch_taken    (branch_taken),
		.branch_target   (branch_target),
		.wb_valid        (wb_valid),
		.dest_reg_addr   (dest_reg_addr),
		.wb_data         (wb_data),
		.reg_wr_en       (reg_wr_en),
		.store_to_mem    (store_to_mem),
		.data_rd_addr    (data_rd_addr),
		.data_wr_addr    (data_wr_addr)
	);

endmodule

// File: dv/core_tb.sv
`timescale 1ns/1ns

module core_tb;

	localparam int NUM_TESTS = 5;
	localparam int PROG_LEN  = 200;
	localparam int IMEM_SIZE = 1024;
	localparam int DRAIN     = 6;
	// Instructions x 4 + 50, summed over tests
	localparam int CYCLE_LIMIT = NUM_TESTS * (PROG_LEN * 4 + 50);

	// Opcode mix per test
	// Flags test alternates setters [0:3] with jumps [4:7]
	localparam logic [4:0] MIX [NUM_TESTS][8] = '{
		'{core_pkg::OPC_ADD, core_pkg::OPC_SUB, core_pkg::OPC_SHL, core_pkg::OPC_AND,
			core_pkg::OPC_OR, core_pkg::OPC_NOT, core_pkg::OPC_ADD, core_pkg::OPC_SUB},
		'{core_pkg::OPC_LOAD, core_pkg::OPC_STORE, core_pkg::OPC_LOAD, core_pkg::OPC_STORE,
			core_pkg::OPC_ADD, core_pkg::OPC_SUB, core_pkg::OPC_OR, core_pkg::OPC_NOT},
		'{core_pkg::OPC_JMP, core_pkg::OPC_JMPGT, core_pkg::OPC_JMPLT, core_pkg::OPC_JMPEQ,
			core_pkg::OPC_JMPC, core_pkg::OPC_CMP, core_pkg::OPC_ADD, core_pkg::OPC_SUB},
		'{core_pkg::OPC_CMP, core_pkg::OPC_ADD, core_pkg::OPC_SUB, core_pkg::OPC_SHL,
			core_pkg::OPC_JMPGT, core_pkg::OPC_JMPLT, core_pkg::OPC_JMPEQ, core_pkg::OPC_JMPC},
		'{5'h03, 5'h04, 5'h05, 5'h1e,
			core_pkg::OPC_CMP, core_pkg::OPC_JMPEQ, core_pkg::OPC_ADD, core_pkg::OPC_JMPC}
	};

	logic                 clk;
	logic                 reset;
	core_pkg::instr_t     instr_mem_data;
	core_pkg::pc_t        prog_ctr;
	core_pkg::reg_addr_t  op1_addr;
	core_pkg::reg_addr_t  op2_addr;
	core_pkg::data_t      op1_rd_data;
	core_pkg::data_t      op2_rd_data;
	logic                 reg_wr_en;
	core_pkg::reg_addr_t  dest_reg_addr;
	core_pkg::data_t      wb_data;
	logic                 store_to_mem;
	core_pkg::dmem_addr_t data_rd_addr;
	core_pkg::dmem_addr_t data_wr_addr;
	core_pkg::data_t      datamem_rd_data;

	// Testbench memories and register file
	logic [15:0]     imem [IMEM_SIZE];
	core_pkg::data_t rf [8];
	core_pkg::data_t rf_init [8];
	core_pkg::data_t dm [256];
	core_pkg::data_t dm_init [256];

	// Instruction-set model state
	core_pkg::data_t m_regs [8];
	core_pkg::data_t m_dmem [256];
	logic            m_gt;
	logic            m_lt;
	logic            m_eq;
	logic            m_carry;

	// Expected commits in program order
	bit exp_store [$];
	int exp_addr [$];
	int exp_data [$];

	int cycles = 0;
	int test_errors;
	int total_errors;
	int tests_failed;

	processor_core UUT (
		.clk             (clk),
		.reset           (reset),
		.instr_mem_data  (instr_mem_data),
		.prog_ctr        (prog_ctr),
		.op1_addr        (op1_addr),
		.op2_addr        (op2_addr),
		.op1_rd_data     (op1_rd_data),
		.op2_rd_data     (op2_rd_data),
		.reg_wr_en       (reg_wr_en),
		.dest_reg_addr   (dest_reg_addr),
		.wb_data         (wb_data),
		.store_to_mem    (store_to_mem),
		.data_rd_addr    (data_rd_addr),
		.data_wr_addr    (data_wr_addr),
		.datamem_rd_data (datamem_rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------
	// Memory and register file side
	// ------------------------------
	// All three read combinationally
	assign instr_mem_data  = imem[prog_ctr];
	assign op1_rd_data     = rf[op1_addr];
	assign op2_rd_data     = rf[op2_addr];
	assign datamem_rd_data = dm[data_rd_addr];

	// Reload from the test image while in reset, else take commits
	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 8; i++)
				rf[i] <= rf_init[i];
			for (int i = 0; i < 256; i++)
				dm[i] <= dm_init[i];
		end
		else
		begin
			if (reg_wr_en)
				rf[dest_reg_addr] <= wb_data;
			if (store_to_mem)
				dm[data_wr_addr] <= wb_data;
		end
	end

	// Run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Run stopped after %0d cycles, the DUT stopped committing", cycles);
			$display("Errors found");
			$finish;
		end
	end

	function automatic string test_name(input int t);
		case (t)
			0: return "alu";
			1: return "load_store";
			2: return "branch";
			3: return "flags";
			default: return "nop";
		endcase
	endfunction

	// ------------------------------
	// Program generation
	// ------------------------------
	task automatic build_program(input int t);
		logic [15:0] w;
		logic [4:0]  op;
		int          tgt;
		int          idx;
		for (int i = 0; i < 8; i++)
			rf_init[i] = 8'($urandom);
		for (int i = 0; i < 256; i++)
			dm_init[i] = 8'($urandom);
		for (int i = 0; i < IMEM_SIZE; i++)
		begin
			idx = (t == 3) ? (i % 2) * 4 + int'($urandom % 4) : int'($urandom % 8);
			op = MIX[t][idx];
			// Forward targets only, so each program runs out
			tgt = i + 1 + int'($urandom % 6);
			if (tgt > PROG_LEN)
				tgt = PROG_LEN;
			// Don't-care bits stay random
			w = 16'($urandom);
			w[15:11] = op;
			if (op == core_pkg::OPC_JMP || (op >= core_pkg::OPC_JMPGT && op <= core_pkg::OPC_JMPC))
				w[9:0] = 10'(tgt);
			else
			begin
				// Four registers only, dense reuse
				w[10:8] = 3'($urandom % 4);
				w[6:4]  = 3'($urandom % 4);
				w[2:0]  = 3'($urandom % 4);
			end
			imem[i] = w;
		end
		// Parking loop, commits nothing
		imem[PROG_LEN] = {core_pkg::OPC_JMP, 1'b0, 10'(PROG_LEN)};
	endtask

	// ------------------------------
	// Instruction-set model
	// ------------------------------
	task automatic record_commit(input bit is_store, input int addr, input core_pkg::data_t v);
		exp_store.push_back(is_store);
		exp_addr.push_back(addr);
		exp_data.push_back(int'(v));
	endtask

	task automatic run_model();
		int              pc;
		int              d;
		logic [15:0]     w;
		logic [8:0]      sum;
		core_pkg::data_t a;
		core_pkg::data_t b;
		exp_store.delete();
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 8; i++)
			m_regs[i] = rf_init[i];
		for (int i = 0; i < 256; i++)
			m_dmem[i] = dm_init[i];
		{m_gt, m_lt, m_eq, m_carry} = 4'b0;
		pc = 0;
		while (pc < PROG_LEN)
		begin
			w = imem[pc];
			d = int'(w[10:8]);
			a = m_regs[w[2:0]];
			b = m_regs[w[6:4]];
			pc = pc + 1;
			case (w[15:11])
				core_pkg::OPC_ADD:
				begin
					sum = 9'(a) + 9'(b);
					m_carry = sum[8];
					m_regs[d] = sum[7:0];
				end
				// Carry means no borrow
				core_pkg::OPC_SUB:
				begin
					m_carry = (a >= b);
					m_regs[d] = a - b;
				end
				core_pkg::OPC_SHL:
				begin
					m_carry = a[7];
					m_regs[d] = {a[6:0], 1'b0};
				end
				core_pkg::OPC_AND:
					m_regs[d] = a & b;
				core_pkg::OPC_OR:
					m_regs[d] = a | b;
				core_pkg::OPC_NOT:
					m_regs[d] = ~a;
				// Unsigned compare, carry untouched
				core_pkg::OPC_CMP:
				begin
					m_gt = (a > b);
					m_lt = (a < b);
					m_eq = (a == b);
				end
				core_pkg::OPC_LOAD:
					m_regs[d] = m_dmem[w[7:0]];
				core_pkg::OPC_STORE:
				begin
					m_dmem[w[10:3]] = a;
					record_commit(1'b1, int'(w[10:3]), a);
				end
				core_pkg::OPC_JMP:
					pc = int'(w[9:0]);
				core_pkg::OPC_JMPGT:
					pc = m_gt ? int'(w[9:0]) : pc;
				core_pkg::OPC_JMPLT:
					pc = m_lt ? int'(w[9:0]) : pc;
				core_pkg::OPC_JMPEQ:
					pc = m_eq ? int'(w[9:0]) : pc;
				core_pkg::OPC_JMPC:
					pc = m_carry ? int'(w[9:0]) : pc;
				default:
					d = -1;
			endcase
			// Register writers commit their new value
			if (w[15:11] inside {core_pkg::OPC_ADD, core_pkg::OPC_SUB, core_pkg::OPC_SHL,
				core_pkg::OPC_AND, core_pkg::OPC_OR, core_pkg::OPC_NOT, core_pkg::OPC_LOAD})
				record_commit(1'b0, d, m_regs[d]);
		end
	endtask

	// ------------------------------
	// Checks
	// ------------------------------
	task automatic check_commit();
		bit    e_store;
		int    e_addr;
		int    e_data;
		int    got_addr;
		string sig;
		if (exp_store.size() == 0)
		begin
			$display("Unexpected commit at %0t after the program had no commits left", $time);
			test_errors++;
		end
		else
		begin
			e_store = exp_store.pop_front();
			e_addr = exp_addr.pop_front();
			e_data = exp_data.pop_front();
			got_addr = e_store ? int'(data_wr_addr) : int'(dest_reg_addr);
			sig = e_store ? "data_wr_addr" : "dest_reg_addr";
			if (store_to_mem != e_store)
			begin
				$display("Fail %0t store_to_mem expected %0d got %0d", $time, e_store, store_to_mem);
				test_errors++;
			end
			if (got_addr != e_addr)
			begin
				$display("Fail %0t %s expected %0d got %0d", $time, sig, e_addr, got_addr);
				test_errors++;
			end
			if (int'(wb_data) != e_data)
			begin
				$display("Fail %0t wb_data expected %0h got %0h", $time, e_data, wb_data);
				test_errors++;
			end
		end
	endtask

	task automatic run_test(input int t);
		int drain;
		int commits;
		@(negedge clk);
		reset = 1'b1;
		test_errors = 0;
		build_program(t);
		run_model();
		repeat (5) @(negedge clk);
		reset = 1'b0;
		// Out of reset, nothing in flight
		if (prog_ctr != '0)
		begin
			$display("Fail %0t prog_ctr expected 0 got %0d", $time, prog_ctr);
			test_errors++;
		end
		if (reg_wr_en || store_to_mem)
		begin
			$display("Commit enable high right after reset at %0t", $time);
			test_errors++;
		end
		drain = 0;
		commits = 0;
		// Mid-cycle sampling, then a few idle cycles to catch extras
		while (drain < DRAIN)
		begin
			@(negedge clk);
			if (reg_wr_en || store_to_mem)
			begin
				check_commit();
				commits++;
			end
			if (exp_store.size() == 0)
				drain++;
		end
		if (test_errors == 0)
			$display("Test %0d %s passed, %0d commits checked", t, test_name(t), commits);
		else
		begin
			$display("Test %0d %s failed with %0d mismatches", t, test_name(t), test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
	endtask

	initial
	begin
		reset = 1'b1;
		total_errors = 0;
		tests_failed = 0;
		test_errors = 0;
		void'($urandom(38418));
		for (int i = 0; i < IMEM_SIZE; i++)
			imem[i] = '0;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("Tests run %0d, failed %0d, mismatches %0d", NUM_TESTS, tests_failed,
			total_errors);
		if (total_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: sim.f
common/core_pkg.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
execute/alu.sv
execute/execute_writeback.sv
rtl/processor_core.sv
dv/core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = core_tb
FILELIST  = sim.f

SRCS    = $(shell cat $(FILELIST))
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
